/* design/acq_pkg.sv */
// acquisition channel definitions
// sample, buffer and bus widths
// system bus register map
// capture state and trigger edge encodings
package acq_pkg;

  ////////////////////////////////////////
  // sample stream
  ////////////////////////////////////////

  // adc resolution
  localparam int unsigned smp_w = 14;

  // signed two's complement adc word
  typedef logic signed [smp_w-1:0] sample_t;

  // decimation factor, 0 behaves as 1
  localparam int unsigned dec_w = 8;

  typedef logic [dec_w-1:0] dec_t;

  ////////////////////////////////////////
  // capture buffer
  ////////////////////////////////////////

  // 1024 samples deep
  localparam int unsigned buf_aw = 10;

  typedef logic [buf_aw-1:0] buf_addr_t;

  ////////////////////////////////////////
  // system bus
  ////////////////////////////////////////

  // byte addressed, 32 bit words
  localparam int unsigned bus_aw = 16;
  localparam int unsigned bus_dw = 32;

  // sample i of the buffer sits at buf_base + 4*i
  localparam logic [bus_aw-1:0] buf_base = 16'h8000;

  // register offsets below the buffer window
  typedef enum logic [bus_aw-1:0] {
    // bit0 arm, bit1 abort
    REG_CTRL   = 16'h0000,
    // capture state in bits 1:0
    REG_STATUS = 16'h0004,
    REG_DEC    = 16'h0008,
    REG_LEVEL  = 16'h000C,
    REG_EDGE   = 16'h0010,
    // samples stored after the trigger
    REG_POST   = 16'h0014,
    // buffer index of the trigger sample
    REG_TPTR   = 16'h0018,
    REG_WPTR   = 16'h001C
  } reg_addr_t;

  ////////////////////////////////////////
  // capture control
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    ACQ_IDLE  = 2'd0,
    ACQ_ARMED = 2'd1,
    ACQ_POST  = 2'd2,
    ACQ_DONE  = 2'd3
  } acq_state_t;

  typedef enum logic {
    TRG_RISE = 1'b0,
    TRG_FALL = 1'b1
  } trg_edge_t;

endpackage : acq_pkg

/* design/acq_decimator.sv */
// sample decimator
// passes one strobed sample in every dec and registers it
`timescale 1ns/1ps

module acq_decimator (
  // clock and reset
  input  logic             bus,
  input  logic             ctl_rst,
  // phase clear, driven by the arm pulse
  input  logic             clr,
  // decimation factor
  input  acq_pkg::dec_t    dec,
  // adc stream
  input  logic             str_vld,
  input  acq_pkg::sample_t str_dat,
  // kept samples
  output logic             dec_vld,
  output acq_pkg::sample_t dec_dat
);

  import acq_pkg::*;

  ////////////////////////////////////////
  // phase counter
  ////////////////////////////////////////

  dec_t phase;
  // last phase value before wrap
  dec_t last;
  logic keep;

  // dec of 0 keeps every sample, same as 1
  assign last = (dec == '0) ? '0 : dec - 1'b1;

  // >= also covers dec lowered mid run
  assign keep = (phase >= last);

  always_ff @(posedge bus) begin
    if (ctl_rst || clr) begin
      phase <= '0;
    end else if (str_vld) begin
      if (keep) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  // strobe, one cycle after input
  always_ff @(posedge bus) begin
    if (ctl_rst || clr) begin
      dec_vld <= 1'b0;
    end else begin
      dec_vld <= str_vld && keep;
    end
  end

  // data only loads on a kept sample
  always_ff @(posedge bus) begin
    if (str_vld && keep) begin
      dec_dat <= str_dat;
    end
  end

endmodule : acq_decimator

/* design/acq_trigger.sv */
// level trigger on the kept sample stream
// rising or falling crossing, signed compare
`timescale 1ns/1ps

module acq_trigger (
  // clock and reset
  input  logic               bus,
  input  logic               ctl_rst,
  // empties the sample history
  input  logic               clr,
  // kept samples
  input  logic               dec_vld,
  input  acq_pkg::sample_t   dec_dat,
  // configuration
  input  acq_pkg::sample_t   level,
  input  acq_pkg::trg_edge_t trg_edge,
  // crossing pulse, only with dec_vld
  output logic               trg
);

  import acq_pkg::*;

  ////////////////////////////////////////
  // previous kept sample
  ////////////////////////////////////////

  sample_t prev;
  logic    prev_ok;

  always_ff @(posedge bus) begin
    if (ctl_rst || clr) begin
      prev_ok <= 1'b0;
    end else if (dec_vld) begin
      prev_ok <= 1'b1;
    end
  end

  always_ff @(posedge bus) begin
    if (dec_vld) begin
      prev <= dec_dat;
    end
  end

  ////////////////////////////////////////
  // crossing detect
  ////////////////////////////////////////

  logic rise;
  logic fall;

  // below -> at or above
  assign rise = (prev < level) && (dec_dat >= level);
  // above -> at or below
  assign fall = (prev > level) && (dec_dat <= level);

  // no history means no crossing
  assign trg = dec_vld && prev_ok && ((trg_edge == TRG_FALL) ? fall : rise);

endmodule : acq_trigger

/* design/acq_control.sv */
// capture controller
// state machine idle/armed/post/done
// post trigger sample counter, trigger pointer capture
`timescale 1ns/1ps

module acq_control (
  // clock and reset
  input  logic                bus,
  input  logic                ctl_rst,
  // software commands, one cycle pulses
  input  logic                arm,
  input  logic                abort,
  // kept samples and trigger
  input  logic                dec_vld,
  input  logic                trg,
  // samples stored after the trigger
  input  acq_pkg::buf_addr_t  post,
  // current buffer write position
  input  acq_pkg::buf_addr_t  wptr,
  // buffer write control
  output logic                wr_en,
  output logic                wr_clr,
  // status
  output acq_pkg::acq_state_t state,
  output acq_pkg::buf_addr_t  tptr,
  output logic                acq_done
);

  import acq_pkg::*;

  ////////////////////////////////////////
  // capture fsm
  ////////////////////////////////////////

  // kept samples since the trigger
  buf_addr_t cnt;

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      state <= ACQ_IDLE;
      cnt   <= '0;
    end else if (abort) begin
      // abort wins over a same cycle arm
      state <= ACQ_IDLE;
    end else if (arm) begin
      state <= ACQ_ARMED;
    end else begin
      case (state)
        ACQ_ARMED: begin
          if (trg) begin
            cnt   <= '0;
            // zero post ends right after the trigger sample
            state <= (post == '0) ? ACQ_DONE : ACQ_POST;
          end
        end
        ACQ_POST: begin
          if (dec_vld) begin
            if (cnt == post - 1'b1) begin
              state <= ACQ_DONE;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        // idle and done wait for a command
        default: begin
          state <= state;
        end
      endcase
    end
  end

  // trigger sample lands at the current wptr
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      tptr <= '0;
    end else if (state == ACQ_ARMED && trg && !arm && !abort) begin
      tptr <= wptr;
    end
  end

  ////////////////////////////////////////
  // buffer control
  ////////////////////////////////////////

  // registered arm resets the write pointer
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      wr_clr <= 1'b0;
    end else begin
      wr_clr <= arm;
    end
  end

  // store while waiting for and after the trigger
  assign wr_en = (state == ACQ_ARMED) || (state == ACQ_POST);

  assign acq_done = (state == ACQ_DONE);

endmodule : acq_control

/* design/str_to_ram.sv */
// circular sample buffer
// stream side write pointer, bus side one cycle read port
`timescale 1ns/1ps

module str_to_ram (
  // clock and reset
  input  logic               bus,
  input  logic               ctl_rst,
  // write pointer clear
  input  logic               clr,
  // write enable from the capture fsm
  input  logic               wr_en,
  // kept samples
  input  logic               dec_vld,
  input  acq_pkg::sample_t   dec_dat,
  // cpu read port
  input  logic               buf_ren,
  input  acq_pkg::buf_addr_t buf_raddr,
  output acq_pkg::sample_t   buf_rdata,
  // next write position
  output acq_pkg::buf_addr_t wptr
);

  import acq_pkg::*;

  // sample storage
  sample_t buf_mem [0:2**buf_aw-1];
  logic    buf_wen;

  ////////////////////////////////////////
  // stream write
  ////////////////////////////////////////

  assign buf_wen = dec_vld && wr_en;

  // wraps naturally at 1024
  always_ff @(posedge bus) begin
    if (ctl_rst || clr) begin
      wptr <= '0;
    end else if (buf_wen) begin
      wptr <= wptr + 1'b1;
    end
  end

  always_ff @(posedge bus) begin
    if (buf_wen) begin
      buf_mem[wptr] <= dec_dat;
    end
  end

  ////////////////////////////////////////
  // cpu read
  ////////////////////////////////////////

  // data valid the cycle after buf_ren
  always_ff @(posedge bus) begin
    if (buf_ren) begin
      buf_rdata <= buf_mem[buf_raddr];
    end
  end

endmodule : str_to_ram

/* design/acq_regs.sv */
// system bus register decoder
// configuration registers, command pulses, status
// buffer window access and read data mux
`timescale 1ns/1ps

module acq_regs (
  // clock and reset
  input  logic                           bus,
  input  logic                           ctl_rst,
  // system bus
  input  logic [acq_pkg::bus_aw-1:0]     bus_addr,
  input  logic                           bus_wen,
  input  logic                           bus_ren,
  input  logic [acq_pkg::bus_dw-1:0]     bus_wdata,
  output logic [acq_pkg::bus_dw-1:0]     bus_rdata,
  output logic                           bus_ack,
  output logic                           bus_err,
  // configuration
  output acq_pkg::dec_t                  dec,
  output acq_pkg::sample_t               level,
  output acq_pkg::trg_edge_t             trg_edge,
  output acq_pkg::buf_addr_t             post,
  output logic                           arm,
  output logic                           abort,
  // status
  input  acq_pkg::acq_state_t            state,
  input  acq_pkg::buf_addr_t             tptr,
  input  acq_pkg::buf_addr_t             wptr,
  // buffer read port
  output logic                           buf_ren,
  output acq_pkg::buf_addr_t             buf_raddr,
  input  acq_pkg::sample_t               buf_rdata
);

  import acq_pkg::*;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  logic                buf_hit;
  logic                reg_hit;
  logic [bus_dw-1:0]   reg_val;
  logic                wr_ctrl;

  // 4 KiB window at buf_base, one sample per word
  assign buf_hit = (bus_addr[bus_aw-1:buf_aw+2] == buf_base[bus_aw-1:buf_aw+2]);
  assign buf_raddr = bus_addr[buf_aw+1:2];
  assign buf_ren   = bus_ren && buf_hit;

  // register hit and read value
  always_comb begin
    reg_hit = 1'b1;
    reg_val = '0;
    case (reg_addr_t'(bus_addr))
      REG_CTRL:   reg_val = '0;
      REG_STATUS: reg_val = bus_dw'(state);
      REG_DEC:    reg_val = bus_dw'(dec);
      REG_LEVEL:  reg_val = {{(bus_dw-smp_w){level[smp_w-1]}}, level};
      REG_EDGE:   reg_val = bus_dw'(trg_edge);
      REG_POST:   reg_val = bus_dw'(post);
      REG_TPTR:   reg_val = bus_dw'(tptr);
      REG_WPTR:   reg_val = bus_dw'(wptr);
      default:    reg_hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // commands and configuration
  ////////////////////////////////////////

  assign wr_ctrl = bus_wen && (bus_addr == REG_CTRL);
  // same cycle as the write
  assign arm     = wr_ctrl && bus_wdata[0];
  assign abort   = wr_ctrl && bus_wdata[1];

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      dec      <= dec_t'(1);
      level    <= '0;
      trg_edge <= TRG_RISE;
      post     <= '0;
    end else if (bus_wen && !buf_hit) begin
      case (reg_addr_t'(bus_addr))
        REG_DEC:   dec      <= bus_wdata[dec_w-1:0];
        REG_LEVEL: level    <= bus_wdata[smp_w-1:0];
        REG_EDGE:  trg_edge <= trg_edge_t'(bus_wdata[0]);
        REG_POST:  post     <= bus_wdata[buf_aw-1:0];
        // ctrl pulses, read only and unmapped ignored
        default:   post     <= post;
      endcase
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  logic              buf_sel;
  logic [bus_dw-1:0] reg_rdata;

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      bus_ack <= 1'b0;
      bus_err <= 1'b0;
      buf_sel <= 1'b0;
    end else begin
      bus_ack <= bus_wen || bus_ren;
      // buffer is read only, unmapped offsets fault
      bus_err <= (bus_wen && buf_hit) || ((bus_wen || bus_ren) && !buf_hit && !reg_hit);
      buf_sel <= bus_ren && buf_hit;
    end
  end

  always_ff @(posedge bus) begin
    if (bus_ren && reg_hit) begin
      reg_rdata <= reg_val;
    end
  end

  // samples come back sign extended
  assign bus_rdata = buf_sel ? {{(bus_dw-smp_w){buf_rdata[smp_w-1]}}, buf_rdata} : reg_rdata;

endmodule : acq_regs

/* design/acq_top.sv */
// acquisition channel top
// decimator, trigger, capture control, buffer, register decoder
`timescale 1ns/1ps

module acq_top (
  // clock and reset
  input  logic                       bus,
  input  logic                       ctl_rst,
  // adc stream, no back-pressure
  input  logic                       str_vld,
  input  acq_pkg::sample_t           str_dat,
  // system bus
  input  logic [acq_pkg::bus_aw-1:0] bus_addr,
  input  logic                       bus_wen,
  input  logic                       bus_ren,
  input  logic [acq_pkg::bus_dw-1:0] bus_wdata,
  output logic [acq_pkg::bus_dw-1:0] bus_rdata,
  output logic                       bus_ack,
  output logic                       bus_err,
  // capture finished level
  output logic                       acq_done
);

  import acq_pkg::*;

  ////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////

  // configuration
  dec_t       dec;
  sample_t    level;
  trg_edge_t  trg_edge;
  buf_addr_t  post;
  logic       arm;
  logic       abort;
  // kept stream and trigger
  logic       dec_vld;
  sample_t    dec_dat;
  logic       trg;
  // capture control
  logic       wr_en;
  logic       wr_clr;
  acq_state_t state;
  buf_addr_t  tptr;
  buf_addr_t  wptr;
  // buffer read
  logic       buf_ren;
  buf_addr_t  buf_raddr;
  sample_t    buf_rdata;

  ////////////////////////////////////////
  // channel blocks
  ////////////////////////////////////////

  acq_decimator dec0 (
    .bus(bus), .ctl_rst(ctl_rst), .clr(arm), .dec(dec),
    .str_vld(str_vld), .str_dat(str_dat), .dec_vld(dec_vld), .dec_dat(dec_dat)
  );

  acq_trigger trg0 (
    .bus(bus), .ctl_rst(ctl_rst), .clr(arm), .dec_vld(dec_vld), .dec_dat(dec_dat),
    .level(level), .trg_edge(trg_edge), .trg(trg)
  );

  acq_control ctl0 (
    .bus(bus), .ctl_rst(ctl_rst), .arm(arm), .abort(abort), .dec_vld(dec_vld),
    .trg(trg), .post(post), .wptr(wptr), .wr_en(wr_en), .wr_clr(wr_clr),
    .state(state), .tptr(tptr), .acq_done(acq_done)
  );

  str_to_ram ram0 (
    .bus(bus), .ctl_rst(ctl_rst), .clr(wr_clr), .wr_en(wr_en), .dec_vld(dec_vld),
    .dec_dat(dec_dat), .buf_ren(buf_ren), .buf_raddr(buf_raddr),
    .buf_rdata(buf_rdata), .wptr(wptr)
  );

  acq_regs regs0 (
    .bus(bus), .ctl_rst(ctl_rst), .bus_addr(bus_addr), .bus_wen(bus_wen),
    .bus_ren(bus_ren), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
    .bus_ack(bus_ack), .bus_err(bus_err), .dec(dec), .level(level),
    .trg_edge(trg_edge), .post(post), .arm(arm), .abort(abort), .state(state),
    .tptr(tptr), .wptr(wptr), .buf_ren(buf_ren), .buf_raddr(buf_raddr),
    .buf_rdata(buf_rdata)
  );

endmodule : acq_top

/* tests/acq_chk.sv */
// protocol assertions for the acquisition channel
// bus acknowledge timing, error qualification, trigger and buffer write rules
`timescale 1ns/1ps

module acq_chk (
  input logic                bus,
  input logic                ctl_rst,
  // system bus
  input logic                bus_wen,
  input logic                bus_ren,
  input logic                bus_ack,
  input logic                bus_err,
  // input stream
  input logic                str_vld,
  // kept stream and capture
  input logic                dec_vld,
  input logic                trg,
  input logic                wr_clr,
  input acq_pkg::buf_addr_t  wptr,
  input acq_pkg::acq_state_t state
);

  import acq_pkg::*;

  // failed assertions so far, read by the testbench
  int fail_cnt = 0;

  // ack on the cycle after each request, never otherwise
  a_ack_timing: assert property (@(posedge bus) disable iff (ctl_rst)
    bus_ack == $past(bus_wen || bus_ren))
    else begin
      fail_cnt++;
      $error("bus_ack does not follow a request by exactly one cycle");
    end

  a_err_with_ack: assert property (@(posedge bus) disable iff (ctl_rst)
    bus_err |-> bus_ack)
    else begin
      fail_cnt++;
      $error("bus_err high without bus_ack");
    end

  // trigger only on a kept sample of the previous strobe
  a_trg_with_vld: assert property (@(posedge bus) disable iff (ctl_rst)
    trg |-> (dec_vld && $past(str_vld)))
    else begin
      fail_cnt++;
      $error("trg high without dec_vld from a strobed sample");
    end

  // write pointer only moves in armed or post, or on a clear
  a_write_state: assert property (@(posedge bus) disable iff (ctl_rst)
    (!(state inside {ACQ_ARMED, ACQ_POST}) && !wr_clr) |=> $stable(wptr))
    else begin
      fail_cnt++;
      $error("buffer write outside the armed and post states");
    end

endmodule : acq_chk

bind acq_top acq_chk chk0 (
  .bus(bus), .ctl_rst(ctl_rst), .bus_wen(bus_wen), .bus_ren(bus_ren),
  .bus_ack(bus_ack), .bus_err(bus_err), .str_vld(str_vld), .dec_vld(dec_vld),
  .trg(trg), .wr_clr(wr_clr), .wptr(wptr), .state(state)
);

/* tests/acq_tb.sv */
// testbench for the acquisition channel
// lfsr stimulus, bus access tasks, capture reference model
// typed compare tasks, watchdog
`timescale 1ns/1ps

module acq_tb;

  import acq_pkg::*;

  localparam int n_runs = 6;
  // stream cycles per run, gaps included
  localparam int smp_per_run = 10000;
  // in ns, four times the expected length
  localparam longint t_limit = longint'(n_runs) * (smp_per_run + 2 * 1024) * 10 * 4;

  logic              bus;
  logic              ctl_rst;
  logic              str_vld;
  sample_t           str_dat;
  logic [bus_aw-1:0] bus_addr;
  logic              bus_wen;
  logic              bus_ren;
  logic [bus_dw-1:0] bus_wdata;
  logic [bus_dw-1:0] bus_rdata;
  logic              bus_ack;
  logic              bus_err;
  logic              acq_done;

  int val_errs;
  int proto_errs;

  acq_top dut0 (
    .bus(bus), .ctl_rst(ctl_rst), .str_vld(str_vld), .str_dat(str_dat),
    .bus_addr(bus_addr), .bus_wen(bus_wen), .bus_ren(bus_ren), .bus_wdata(bus_wdata),
    .bus_rdata(bus_rdata), .bus_ack(bus_ack), .bus_err(bus_err), .acq_done(acq_done)
  );

  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  ////////////////////////////////////////
  // random bits
  ////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  logic [31:0] lfsr_q = 32'd66155;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      val_errs++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input acq_state_t exp, input acq_state_t act);
    if (act !== exp) begin
      val_errs++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input buf_addr_t exp, input buf_addr_t act);
    if (act !== exp) begin
      val_errs++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      val_errs++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  sample_t    m_mem [0:1023];
  logic       m_known [0:1023];
  acq_state_t m_state;
  buf_addr_t  m_wptr;
  buf_addr_t  m_tptr;
  buf_addr_t  m_cnt;
  int         m_phase;
  sample_t    m_prev;
  logic       m_prev_ok;
  // configuration as written to the dut
  dec_t       cfg_dec;
  sample_t    cfg_level;
  trg_edge_t  cfg_edge;
  buf_addr_t  cfg_post;

  // one kept sample through trigger and capture
  task automatic model_kept(input sample_t x);
    logic hit;
    logic wr;
    if (cfg_edge == TRG_RISE) begin
      hit = (m_prev < cfg_level) && (x >= cfg_level);
    end else begin
      hit = (m_prev > cfg_level) && (x <= cfg_level);
    end
    hit = hit && m_prev_ok;
    wr  = (m_state == ACQ_ARMED) || (m_state == ACQ_POST);
    if (wr) begin
      m_mem[m_wptr]   = x;
      m_known[m_wptr] = 1'b1;
    end
    if (m_state == ACQ_ARMED && hit) begin
      m_tptr  = m_wptr;
      m_cnt   = '0;
      m_state = (cfg_post == '0) ? ACQ_DONE : ACQ_POST;
    end else if (m_state == ACQ_POST) begin
      if (m_cnt == buf_addr_t'(cfg_post - 1'b1)) begin
        m_state = ACQ_DONE;
      end else begin
        m_cnt++;
      end
    end
    if (wr) begin
      m_wptr++;
    end
    m_prev    = x;
    m_prev_ok = 1'b1;
  endtask

  // keep every dec-th strobe, counted from the arm
  task automatic model_strobe(input sample_t x);
    int de;
    de = (cfg_dec == '0) ? 1 : int'(cfg_dec);
    if (m_phase == de - 1) begin
      m_phase = 0;
      model_kept(x);
    end else begin
      m_phase++;
    end
  endtask

  ////////////////////////////////////////
  // stream and bus drivers
  ////////////////////////////////////////

  task automatic drive_sample(input sample_t x, input logic gap);
    if (gap) begin
      @(posedge bus);
      str_vld <= 1'b0;
    end
    @(posedge bus);
    str_vld <= 1'b1;
    str_dat <= x;
    model_strobe(x);
  endtask

  // lets the decimator and buffer pipeline drain
  task automatic stream_idle(input int n);
    repeat (n) begin
      @(posedge bus);
      str_vld <= 1'b0;
    end
  endtask

  task automatic bus_access(input logic wr, input logic [bus_aw-1:0] addr,
                            input logic [bus_dw-1:0] wdata,
                            output logic [bus_dw-1:0] rdata, output logic err);
    @(posedge bus);
    bus_addr  <= addr;
    bus_wen   <= wr;
    bus_ren   <= !wr;
    bus_wdata <= wdata;
    @(posedge bus);
    bus_wen <= 1'b0;
    bus_ren <= 1'b0;
    // ack and data settle away from the edge
    @(negedge bus);
    if (bus_ack !== 1'b1) begin
      proto_errs++;
      $display("no bus acknowledge one cycle after the request to address %h", addr);
    end
    rdata = bus_rdata;
    err   = bus_err;
  endtask

  task automatic write_reg(input logic [bus_aw-1:0] addr, input logic [bus_dw-1:0] data,
                           input logic exp_err);
    logic [bus_dw-1:0] rd;
    logic              err;
    bus_access(1'b1, addr, data, rd, err);
    check_word($sformatf("bus_err on write to %h", addr), {31'b0, exp_err}, {31'b0, err});
  endtask

  task automatic read_reg(input logic [bus_aw-1:0] addr, output logic [bus_dw-1:0] data,
                          input logic exp_err);
    logic err;
    bus_access(1'b0, addr, '0, data, err);
    check_word($sformatf("bus_err on read from %h", addr), {31'b0, exp_err}, {31'b0, err});
  endtask

  ////////////////////////////////////////
  // test steps
  ////////////////////////////////////////

  task automatic register_test();
    logic [31:0] d;
    logic [31:0] v;
    read_reg(REG_STATUS, d, 1'b0);
    check_state("status after reset", ACQ_IDLE, acq_state_t'(d[1:0]));
    v = rand_bits(32);
    write_reg(REG_DEC, v, 1'b0);
    read_reg(REG_DEC, d, 1'b0);
    check_word("dec readback", {24'b0, v[7:0]}, d);
    v = rand_bits(32);
    write_reg(REG_LEVEL, v, 1'b0);
    read_reg(REG_LEVEL, d, 1'b0);
    // level reads back sign extended
    check_word("level readback", {{18{v[13]}}, v[13:0]}, d);
    v = rand_bits(32);
    write_reg(REG_EDGE, v, 1'b0);
    read_reg(REG_EDGE, d, 1'b0);
    check_word("edge readback", {31'b0, v[0]}, d);
    v = rand_bits(32);
    write_reg(REG_POST, v, 1'b0);
    read_reg(REG_POST, d, 1'b0);
    check_word("post readback", {22'b0, v[9:0]}, d);
    // buffer window is read only
    write_reg(buf_base + 16'h0010, 32'h1234, 1'b1);
    read_reg(16'h0020, d, 1'b1);
    write_reg(16'h0040, 32'h0, 1'b1);
  endtask

  task automatic set_config();
    cfg_dec   = dec_t'(rand_bits(2));
    cfg_level = sample_t'(int'(rand_bits(12)) - 2048);
    cfg_edge  = trg_edge_t'(rand_bits(1));
    cfg_post  = buf_addr_t'(rand_bits(8));
    write_reg(REG_DEC, {24'b0, cfg_dec}, 1'b0);
    write_reg(REG_LEVEL, {18'b0, cfg_level}, 1'b0);
    write_reg(REG_EDGE, {31'b0, cfg_edge}, 1'b0);
    write_reg(REG_POST, {22'b0, cfg_post}, 1'b0);
  endtask

  task automatic arm_capture();
    write_reg(REG_CTRL, 32'h1, 1'b0);
    m_state   = ACQ_ARMED;
    m_wptr    = '0;
    m_phase   = 0;
    m_prev_ok = 1'b0;
  endtask

  // stays on the side of the level that cannot trigger
  function automatic sample_t quiet_sample();
    logic [31:0] r;
    r = rand_bits(8);
    if (cfg_edge == TRG_RISE) begin
      return cfg_level - 1 - r[7:0];
    end
    return cfg_level + 1 + r[7:0];
  endfunction

  task automatic check_capture();
    logic [31:0]       d;
    buf_addr_t         tp;
    logic [bus_aw-1:0] a;
    read_reg(REG_STATUS, d, 1'b0);
    check_state("capture state", m_state, acq_state_t'(d[1:0]));
    if (acq_done !== (m_state == ACQ_DONE)) begin
      proto_errs++;
      $display("acq_done level does not match the capture state");
    end
    read_reg(REG_TPTR, d, 1'b0);
    tp = buf_addr_t'(d);
    check_addr("trigger pointer", m_tptr, tp);
    read_reg(REG_WPTR, d, 1'b0);
    check_addr("write pointer", m_wptr, buf_addr_t'(d));
    if (m_state == ACQ_DONE) begin
      check_addr("write pointer after post", buf_addr_t'(m_tptr + cfg_post + 1),
                 buf_addr_t'(d));
    end
    for (int i = 0; i < 1024; i++) begin
      if (m_known[i]) begin
        a = buf_base + bus_aw'(4 * i);
        read_reg(a, d, 1'b0);
        check_sample($sformatf("buffer[%0d]", i), m_mem[i], sample_t'(d[smp_w-1:0]));
      end
    end
  endtask

  // late runs hold the trigger off past a full buffer
  task automatic capture_run(input logic late);
    int de;
    int n_quiet;
    int n_tail;
    set_config();
    arm_capture();
    de      = (cfg_dec == '0) ? 1 : int'(cfg_dec);
    n_quiet = int'(rand_bits(6)) + (late ? 1100 : 0);
    for (int i = 0; i < n_quiet * de; i++) begin
      drive_sample(quiet_sample(), rand_bits(1));
    end
    // random tail, long enough to trigger and finish post
    n_tail = (int'(cfg_post) + 200) * de;
    for (int i = 0; i < n_tail; i++) begin
      drive_sample(sample_t'(rand_bits(smp_w)), rand_bits(1));
    end
    stream_idle(4);
    if (m_state != ACQ_DONE) begin
      proto_errs++;
      $display("stimulus of a capture run never completed a capture");
    end
    check_capture();
  endtask

  task automatic abort_test();
    logic [31:0] d;
    buf_addr_t   wp;
    set_config();
    arm_capture();
    for (int i = 0; i < 40; i++) begin
      drive_sample(quiet_sample(), rand_bits(1));
    end
    stream_idle(4);
    write_reg(REG_CTRL, 32'h2, 1'b0);
    m_state = ACQ_IDLE;
    read_reg(REG_STATUS, d, 1'b0);
    check_state("state after abort", ACQ_IDLE, acq_state_t'(d[1:0]));
    read_reg(REG_WPTR, d, 1'b0);
    wp = buf_addr_t'(d);
    check_addr("write pointer at abort", m_wptr, wp);
    for (int i = 0; i < 100; i++) begin
      drive_sample(sample_t'(rand_bits(smp_w)), rand_bits(1));
    end
    stream_idle(4);
    read_reg(REG_WPTR, d, 1'b0);
    check_addr("write pointer after abort", m_wptr, buf_addr_t'(d));
    check_capture();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    ctl_rst   = 1'b1;
    str_vld   = 1'b0;
    str_dat   = '0;
    bus_addr  = '0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    bus_wdata = '0;
    val_errs   = 0;
    proto_errs = 0;
    m_state   = ACQ_IDLE;
    m_wptr    = '0;
    m_tptr    = '0;
    m_cnt     = '0;
    m_phase   = 0;
    m_prev    = '0;
    m_prev_ok = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      m_known[i] = 1'b0;
    end
    repeat (4) @(posedge bus);
    ctl_rst <= 1'b0;
    register_test();
    // last two runs wrap the buffer
    for (int r = 0; r < n_runs; r++) begin
      capture_run(r >= n_runs - 2);
    end
    abort_test();
    $display("errors: %0d value, %0d protocol, %0d assertion",
             val_errs, proto_errs, dut0.chk0.fail_cnt);
    if (val_errs + proto_errs + dut0.chk0.fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(t_limit);
    $display("watchdog expired after %0d ns, the run did not finish", t_limit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule : acq_tb

/* filelist.f */
design/acq_pkg.sv
design/acq_decimator.sv
design/acq_trigger.sv
design/acq_control.sv
design/str_to_ram.sv
design/acq_regs.sv
design/acq_top.sv
tests/acq_chk.sv
tests/acq_tb.sv

/* Bender.yml */
package:
  name: acq_channel

sources:
  - files:
      - design/acq_pkg.sv
      - design/acq_decimator.sv
      - design/acq_trigger.sv
      - design/acq_control.sv
      - design/str_to_ram.sv
      - design/acq_regs.sv
      - design/acq_top.sv
  - target: test
    files:
      - tests/acq_chk.sv
      - tests/acq_tb.sv
